// File: all.f
+incdir+logic
logic/unpack_pkg.sv
logic/unpack_fsm.sv
logic/rx_header_decode.sv
logic/rx_payload_reader.sv
logic/randombit_packer.sv
logic/rx_unpacket.sv
testbench/rx_unpacket_asserts.sv
testbench/tb_rx_unpacket.sv

// File: logic/randombit_packer.sv
`include "unpack_cfg.svh"

module randombit_packer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ev_clear,
    input  logic                          pkt_end,
    input  unpack_pkg::pkt_type_t         pkt_type,
    input  logic                          payload_we,
    input  unpack_pkg::word_t             payload_word,
    output logic                          rb_we,
    output logic [`UNPACK_RB_ADDR_W-1:0]  rb_addr,
    output logic [2*`UNPACK_WORD_W-1:0]   rb_din,
    output logic                          ev_full
);

    localparam int unsigned CNT_W = $clog2(`RB_FULL_PACKETS + 1);

    unpack_pkg::word_t prev_word;
    logic              odd_word;
    logic [CNT_W-1:0]  ev_pkt_cnt;

    // Pair phase restarts with every packet
    always_ff @(posedge clk) begin
        if (!rst_n || pkt_end) begin
            odd_word <= 1'b0;
        end else if (payload_we) begin
            odd_word <= !odd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (payload_we) begin
            prev_word <= payload_word;
        end
        if (payload_we && odd_word) begin
            rb_din <= {prev_word, payload_word};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rb_we <= 1'b0;
        end else begin
            rb_we <= payload_we && odd_word;
        end
    end

    // Address keeps running across packets until cleared
    always_ff @(posedge clk) begin
        if (!rst_n || ev_clear) begin
            rb_addr <= '0;
        end else if (rb_we) begin
            rb_addr <= rb_addr + 1'b1;
        end
    end

    // Count holds at the threshold until software clears it
    always_ff @(posedge clk) begin
        if (!rst_n || ev_clear) begin
            ev_pkt_cnt <= '0;
        end else if (pkt_end && (pkt_type == unpack_pkg::PKT_EV_RANDOMBIT) && !ev_full) begin
            ev_pkt_cnt <= ev_pkt_cnt + 1'b1;
        end
    end

    assign ev_full = (ev_pkt_cnt == CNT_W'(`RB_FULL_PACKETS));

endmodule

// File: logic/rx_header_decode.sv
`include "unpack_cfg.svh"

module rx_header_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hdr_load,
    input  logic                  pkt_end,
    input  unpack_pkg::word_t     header,
    output unpack_pkg::pkt_type_t pkt_type,
    output unpack_pkg::depth_t    payload_depth
);

    unpack_pkg::word_t     hdr_q;
    unpack_pkg::len_code_t len_code;

    // Held for the whole message, cleared once it ends
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_q <= '0;
        end else if (hdr_load) begin
            hdr_q <= header;
        end else if (pkt_end) begin
            hdr_q <= '0;
        end
    end

    assign pkt_type = unpack_pkg::pkt_type_t'(hdr_q[`UNPACK_WORD_W-1 -: `UNPACK_TYPE_W]);
    assign len_code = hdr_q[`UNPACK_WORD_W-`UNPACK_TYPE_W-1 -: `UNPACK_LEN_W];

    always_comb begin
        case (len_code)
            `LEN_257: begin
                // Short packets carry their own depth in bits 23:15
                payload_depth = unpack_pkg::depth_t'(hdr_q[23:15]);
            end
            `LEN_514: begin
                payload_depth = `DEPTH_514;
            end
            `LEN_771: begin
                payload_depth = `DEPTH_771;
            end
            default: begin
                payload_depth = `DEPTH_1028;
            end
        endcase
    end

endmodule

// File: logic/rx_payload_reader.sv
module rx_payload_reader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  payload_run,
    input  logic                  pkt_end,
    input  unpack_pkg::pkt_type_t pkt_type,
    input  unpack_pkg::depth_t    payload_depth,
    input  unpack_pkg::word_t     bram_dout,
    output unpack_pkg::depth_t    bram_addr,
    output unpack_pkg::word_t     header_word,
    output logic                  payload_done,
    output logic                  er_wr_en,
    output unpack_pkg::word_t     er_wr_din,
    output logic                  decoy_wr_en,
    output unpack_pkg::word_t     decoy_wr_din,
    output logic                  payload_we,
    output unpack_pkg::word_t     payload_word
);

    // Counter to data: address register, RAM read, output register
    localparam int unsigned RD_LAT = 3;
    // Gap after the last word so the packer finishes before the message ends
    localparam int unsigned DONE_MARGIN = 2;

    unpack_pkg::word_t  dout_q;
    unpack_pkg::depth_t rd_cnt;
    unpack_pkg::depth_t first_cnt;
    unpack_pkg::depth_t last_cnt;
    logic               er_sel;
    logic               decoy_sel;
    logic               ev_sel;
    logic               wr_win;

    always_ff @(posedge clk) begin
        dout_q <= bram_dout;
    end

    // Address 0 stays on the bus outside a payload, so dout_q holds the header
    assign header_word = dout_q;

    always_ff @(posedge clk) begin
        if (!rst_n || pkt_end) begin
            rd_cnt <= '0;
        end else if (payload_run) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bram_addr <= '0;
        end else if (payload_run && (rd_cnt <= payload_depth)) begin
            bram_addr <= rd_cnt;
        end else begin
            bram_addr <= '0;
        end
    end

    assign er_sel    = (pkt_type == unpack_pkg::PKT_CORRECT_PARITY) ||
                       (pkt_type == unpack_pkg::PKT_TARGET_HASHTAG);
    assign decoy_sel = (pkt_type == unpack_pkg::PKT_Z_BASIS_DECOY);
    assign ev_sel    = (pkt_type == unpack_pkg::PKT_EV_RANDOMBIT);

    // Error-reconciliation types open one word early to pass the header on
    assign first_cnt = er_sel ? unpack_pkg::depth_t'(RD_LAT) : unpack_pkg::depth_t'(RD_LAT + 1);
    assign last_cnt  = payload_depth + unpack_pkg::depth_t'(RD_LAT);

    assign wr_win = payload_run && (rd_cnt >= first_cnt) && (rd_cnt <= last_cnt);

    assign payload_done = payload_run &&
                          (rd_cnt == last_cnt + unpack_pkg::depth_t'(DONE_MARGIN));

    // Exactly one destination sees each word
    assign er_wr_en     = wr_win && er_sel;
    assign er_wr_din    = er_wr_en ? dout_q : '0;

    assign decoy_wr_en  = wr_win && decoy_sel;
    assign decoy_wr_din = decoy_wr_en ? dout_q : '0;

    assign payload_we   = wr_win && ev_sel;
    assign payload_word = payload_we ? dout_q : '0;

endmodule

// File: logic/rx_unpacket.sv
`include "unpack_cfg.svh"

module rx_unpacket (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          msg_accessed,
    input  logic                          net_busy,
    output logic                          pp_busy,
    input  logic                          er_full,
    output logic                          er_wr_en,
    output unpack_pkg::word_t             er_wr_din,
    input  logic                          decoy_full,
    output logic                          decoy_wr_en,
    output unpack_pkg::word_t             decoy_wr_din,
    output unpack_pkg::depth_t            bram_addr,
    input  unpack_pkg::word_t             bram_dout,
    output logic                          rb_we,
    output logic [`UNPACK_RB_ADDR_W-1:0]  rb_addr,
    output logic [2*`UNPACK_WORD_W-1:0]   rb_din,
    input  logic                          ev_clear,
    output logic                          ev_full,
    output unpack_pkg::unpack_state_t     state
);

    logic                  hdr_load;
    logic                  payload_run;
    logic                  pkt_end;
    logic                  payload_done;
    logic                  payload_we;
    unpack_pkg::word_t     payload_word;
    unpack_pkg::word_t     header_word;
    unpack_pkg::pkt_type_t pkt_type;
    unpack_pkg::depth_t    payload_depth;

    unpack_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_accessed (msg_accessed),
        .net_busy     (net_busy),
        .er_full      (er_full),
        .decoy_full   (decoy_full),
        .payload_done (payload_done),
        .pp_busy      (pp_busy),
        .hdr_load     (hdr_load),
        .payload_run  (payload_run),
        .pkt_end      (pkt_end),
        .state        (state)
    );

    rx_header_decode u_header_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .hdr_load      (hdr_load),
        .pkt_end       (pkt_end),
        .header        (header_word),
        .pkt_type      (pkt_type),
        .payload_depth (payload_depth)
    );

    rx_payload_reader u_payload_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .payload_run   (payload_run),
        .pkt_end       (pkt_end),
        .pkt_type      (pkt_type),
        .payload_depth (payload_depth),
        .bram_dout     (bram_dout),
        .bram_addr     (bram_addr),
        .header_word   (header_word),
        .payload_done  (payload_done),
        .er_wr_en      (er_wr_en),
        .er_wr_din     (er_wr_din),
        .decoy_wr_en   (decoy_wr_en),
        .decoy_wr_din  (decoy_wr_din),
        .payload_we    (payload_we),
        .payload_word  (payload_word)
    );

    randombit_packer u_randombit_packer (
        .clk          (clk),
        .rst_n        (rst_n),
        .ev_clear     (ev_clear),
        .pkt_end      (pkt_end),
        .pkt_type     (pkt_type),
        .payload_we   (payload_we),
        .payload_word (payload_word),
        .rb_we        (rb_we),
        .rb_addr      (rb_addr),
        .rb_din       (rb_din),
        .ev_full      (ev_full)
    );

endmodule

// File: logic/unpack_cfg.svh
`ifndef UNPACK_CFG_SVH
`define UNPACK_CFG_SVH

// Data path widths
`define UNPACK_WORD_W       32
`define UNPACK_ADDR_W       11
`define UNPACK_RB_ADDR_W    14

// Header field widths, type in the top nibble and length code below it
`define UNPACK_TYPE_W       4
`define UNPACK_LEN_W        4

// Packet type codes
`define TYPE_CORRECT_PARITY 4'd1
`define TYPE_TARGET_HASHTAG 4'd2
`define TYPE_Z_BASIS_DECOY  4'd3
`define TYPE_EV_RANDOMBIT   4'd4

// Length codes
`define LEN_257             4'd1
`define LEN_514             4'd2
`define LEN_771             4'd3
`define LEN_1028            4'd4

// Payload depths for the fixed length codes
`define DEPTH_514           11'd512
`define DEPTH_771           11'd768
`define DEPTH_1028          11'd1024

// EV packets that fill the random-bit RAM
`define RB_FULL_PACKETS     32

`endif

// File: logic/unpack_fsm.sv
module unpack_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      msg_accessed,
    input  logic                      net_busy,
    input  logic                      er_full,
    input  logic                      decoy_full,
    input  logic                      payload_done,
    output logic                      pp_busy,
    output logic                      hdr_load,
    output logic                      payload_run,
    output logic                      pkt_end,
    output unpack_pkg::unpack_state_t state
);

    unpack_pkg::unpack_state_t state_next;
    logic                      start_ok;

    // A message is taken only when the network is done and both FIFOs have room
    assign start_ok = msg_accessed && !net_busy && !er_full && !decoy_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= unpack_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            unpack_pkg::IDLE: begin
                if (start_ok) begin
                    state_next = unpack_pkg::READ_HEADER;
                end
            end
            unpack_pkg::READ_HEADER: begin
                state_next = unpack_pkg::SET_PARAMETER;
            end
            unpack_pkg::SET_PARAMETER: begin
                state_next = unpack_pkg::WRITE_PAYLOAD;
            end
            unpack_pkg::WRITE_PAYLOAD: begin
                if (payload_done) begin
                    state_next = unpack_pkg::UNPACK_DONE;
                end
            end
            unpack_pkg::UNPACK_DONE: begin
                state_next = unpack_pkg::WAIT_NEXT;
            end
            unpack_pkg::WAIT_NEXT: begin
                // Network must withdraw the message before the next one
                if (!msg_accessed) begin
                    state_next = unpack_pkg::IDLE;
                end
            end
            default: begin
                state_next = unpack_pkg::IDLE;
            end
        endcase
    end

    assign pp_busy     = (state != unpack_pkg::IDLE);
    assign hdr_load    = (state == unpack_pkg::READ_HEADER);
    assign payload_run = (state == unpack_pkg::WRITE_PAYLOAD);
    assign pkt_end     = (state == unpack_pkg::UNPACK_DONE);

endmodule

// File: logic/unpack_pkg.sv
`include "unpack_cfg.svh"

package unpack_pkg;

    typedef logic [`UNPACK_WORD_W-1:0] word_t;

    // Word count or receive RAM address
    typedef logic [`UNPACK_ADDR_W-1:0] depth_t;

    typedef logic [`UNPACK_LEN_W-1:0] len_code_t;

    typedef enum logic [`UNPACK_TYPE_W-1:0] {
        PKT_NONE           = 4'd0,
        PKT_CORRECT_PARITY = `TYPE_CORRECT_PARITY,
        PKT_TARGET_HASHTAG = `TYPE_TARGET_HASHTAG,
        PKT_Z_BASIS_DECOY  = `TYPE_Z_BASIS_DECOY,
        PKT_EV_RANDOMBIT   = `TYPE_EV_RANDOMBIT
    } pkt_type_t;

    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        READ_HEADER   = 4'd1,
        SET_PARAMETER = 4'd2,
        WRITE_PAYLOAD = 4'd3,
        UNPACK_DONE   = 4'd4,
        WAIT_NEXT     = 4'd5
    } unpack_state_t;

endpackage

// File: testbench/rx_unpacket_asserts.sv
module rx_unpacket_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      msg_accessed,
    input logic                      net_busy,
    input logic                      er_full,
    input logic                      decoy_full,
    input logic                      pp_busy,
    input logic                      er_wr_en,
    input logic                      decoy_wr_en,
    input logic                      rb_we,
    input logic                      ev_full,
    input unpack_pkg::pkt_type_t     pkt_type,
    input unpack_pkg::unpack_state_t state
);

    int   fail_cnt = 0;
    logic start_ok;

    assign start_ok = msg_accessed && !net_busy && !er_full && !decoy_full;

    // Quiet through reset and on the first cycle after release
    reset_quiet: assert property (@(posedge clk) !rst_n |=>
        (!pp_busy && !er_wr_en && !decoy_wr_en && !rb_we && state == unpack_pkg::IDLE))
    else begin
        fail_cnt++;
        $error("Outputs active during or right after reset");
    end

    // No message starts while the network writes or a FIFO is full
    start_gate: assert property (@(posedge clk) disable iff (!rst_n)
        (state == unpack_pkg::IDLE && !start_ok) |=> !pp_busy)
    else begin
        fail_cnt++;
        $error("Message started while blocked");
    end

    wait_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == unpack_pkg::WAIT_NEXT && msg_accessed) |=> pp_busy)
    else begin
        fail_cnt++;
        $error("Busy dropped while message still offered");
    end

    er_route: assert property (@(posedge clk) disable iff (!rst_n)
        er_wr_en |-> (!decoy_wr_en && !rb_we &&
            (pkt_type == unpack_pkg::PKT_CORRECT_PARITY ||
             pkt_type == unpack_pkg::PKT_TARGET_HASHTAG)))
    else begin
        fail_cnt++;
        $error("ER FIFO write for wrong type");
    end

    decoy_route: assert property (@(posedge clk) disable iff (!rst_n)
        decoy_wr_en |-> (!rb_we && pkt_type == unpack_pkg::PKT_Z_BASIS_DECOY))
    else begin
        fail_cnt++;
        $error("Decoy FIFO write for wrong type");
    end

    rb_route: assert property (@(posedge clk) disable iff (!rst_n)
        rb_we |-> (pkt_type == unpack_pkg::PKT_EV_RANDOMBIT &&
                   state == unpack_pkg::WRITE_PAYLOAD))
    else begin
        fail_cnt++;
        $error("Random-bit write outside an EV payload");
    end

    // Full flag only rises at the end of a packet
    full_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ev_full) |-> $past(state == unpack_pkg::UNPACK_DONE))
    else begin
        fail_cnt++;
        $error("ev_full rose outside a packet end");
    end

endmodule

// File: testbench/tb_rx_unpacket.sv
`include "unpack_cfg.svh"

module tb_rx_unpacket;

    // Longest message about 1,040 cycles, the short ones well under 30
    localparam int TIMEOUT_CYCLES = 10000;
    localparam int RAM_WORDS      = 2048;

    logic                         clk;
    logic                         rst_n;
    logic                         msg_accessed;
    logic                         net_busy;
    logic                         er_full;
    logic                         decoy_full;
    logic                         ev_clear;
    unpack_pkg::word_t            bram_dout;
    logic                         pp_busy;
    logic                         er_wr_en;
    unpack_pkg::word_t            er_wr_din;
    logic                         decoy_wr_en;
    unpack_pkg::word_t            decoy_wr_din;
    unpack_pkg::depth_t           bram_addr;
    logic                         rb_we;
    logic [`UNPACK_RB_ADDR_W-1:0] rb_addr;
    logic [2*`UNPACK_WORD_W-1:0]  rb_din;
    logic                         ev_full;
    unpack_pkg::unpack_state_t    state;

    unpack_pkg::word_t            ram [0:RAM_WORDS-1];
    unpack_pkg::word_t            er_exp[$];
    unpack_pkg::word_t            decoy_exp[$];
    logic [2*`UNPACK_WORD_W-1:0]  rb_exp[$];
    logic [`UNPACK_RB_ADDR_W-1:0] rb_addr_exp;
    integer                       seed;
    int                           err_cnt;
    int                           cycle_cnt;
    int                           er_cnt;
    int                           decoy_cnt;
    int                           rb_cnt;
    int                           er_total;
    int                           decoy_total;
    int                           rb_total;
    int                           n;

    rx_unpacket u_rx_unpacket (.*);

    bind rx_unpacket rx_unpacket_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_accessed (msg_accessed),
        .net_busy     (net_busy),
        .er_full      (er_full),
        .decoy_full   (decoy_full),
        .pp_busy      (pp_busy),
        .er_wr_en     (er_wr_en),
        .decoy_wr_en  (decoy_wr_en),
        .rb_we        (rb_we),
        .ev_full      (ev_full),
        .pkt_type     (pkt_type),
        .state        (state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Receive RAM, one cycle of read latency
    always @(posedge clk) begin
        bram_dout <= ram[bram_addr];
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_unexpected(input string dest);
        err_cnt++;
        $display("Unexpected write to the %s at time %0t", dest, $time);
    endtask

    // Each write is compared with the oldest expected word of its destination
    always @(posedge clk) begin
        if (rst_n) begin
            if (er_wr_en) begin
                er_cnt++;
                if (er_exp.size() == 0) report_unexpected("ER FIFO");
                else check_value("er_wr_din", er_wr_din, er_exp.pop_front());
            end
            if (decoy_wr_en) begin
                decoy_cnt++;
                if (decoy_exp.size() == 0) report_unexpected("decoy FIFO");
                else check_value("decoy_wr_din", decoy_wr_din, decoy_exp.pop_front());
            end
            if (rb_we) begin
                rb_cnt++;
                check_value("rb_addr", rb_addr, rb_addr_exp);
                rb_addr_exp++;
                if (rb_exp.size() == 0) report_unexpected("random-bit RAM");
                else check_value("rb_din", rb_din, rb_exp.pop_front());
            end
        end
    end

    task automatic load_message(input unpack_pkg::pkt_type_t ptype,
                                input unpack_pkg::len_code_t len, input int depth);
        unpack_pkg::word_t hdr;
        int                i;
        for (i = 0; i < RAM_WORDS; i++) begin
            ram[i] = $random(seed);
        end
        hdr = ram[0];
        hdr[31:28] = ptype;
        hdr[27:24] = len;
        if (len == `LEN_257) begin
            hdr[23:15] = depth[8:0];
        end
        ram[0] = hdr;
        if (ptype == unpack_pkg::PKT_CORRECT_PARITY ||
            ptype == unpack_pkg::PKT_TARGET_HASHTAG) begin
            er_exp.push_back(hdr);
            er_total++;
        end
        for (i = 1; i <= depth; i++) begin
            if (ptype == unpack_pkg::PKT_Z_BASIS_DECOY) begin
                decoy_exp.push_back(ram[i]);
                decoy_total++;
            end else if (ptype == unpack_pkg::PKT_EV_RANDOMBIT) begin
                // Pairs go out as {earlier word, later word}
                if (i % 2 == 0) begin
                    rb_exp.push_back({ram[i-1], ram[i]});
                    rb_total++;
                end
            end else begin
                er_exp.push_back(ram[i]);
                er_total++;
            end
        end
    endtask

    task automatic finish_message();
        while (state != unpack_pkg::WAIT_NEXT) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        msg_accessed <= 1'b0;
        while (state != unpack_pkg::IDLE) begin
            @(posedge clk);
        end
        if (er_exp.size() != 0 || decoy_exp.size() != 0 || rb_exp.size() != 0) begin
            err_cnt++;
            $display("Writes missing at end of message: ER %0d, decoy %0d, random-bit %0d",
                     er_exp.size(), decoy_exp.size(), rb_exp.size());
            er_exp.delete();
            decoy_exp.delete();
            rb_exp.delete();
        end
    endtask

    task automatic run_message(input unpack_pkg::pkt_type_t ptype,
                               input unpack_pkg::len_code_t len, input int depth);
        load_message(ptype, len, depth);
        repeat (3) @(posedge clk);
        msg_accessed <= 1'b1;
        finish_message();
    endtask

    task automatic clear_ev();
        @(posedge clk);
        ev_clear <= 1'b1;
        @(posedge clk);
        ev_clear <= 1'b0;
        rb_addr_exp = '0;
        @(posedge clk);
        check_value("rb_addr after clear", rb_addr, 0);
        check_value("ev_full after clear", ev_full, 0);
    endtask

    initial begin
        seed         = 32'h5724866e;
        rst_n        = 1'b0;
        msg_accessed = 1'b0;
        net_busy     = 1'b0;
        er_full      = 1'b0;
        decoy_full   = 1'b0;
        ev_clear     = 1'b0;
        bram_dout    = '0;
        rb_addr_exp  = '0;
        err_cnt      = 0;
        cycle_cnt    = 0;
        er_cnt       = 0;
        decoy_cnt    = 0;
        rb_cnt       = 0;
        er_total     = 0;
        decoy_total  = 0;
        rb_total     = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_message(unpack_pkg::PKT_CORRECT_PARITY, `LEN_257, 20);

        // Offered while each start condition blocks in turn
        load_message(unpack_pkg::PKT_TARGET_HASHTAG, `LEN_257, 5);
        @(posedge clk);
        net_busy     <= 1'b1;
        msg_accessed <= 1'b1;
        repeat (5) @(posedge clk);
        net_busy <= 1'b0;
        er_full  <= 1'b1;
        repeat (5) @(posedge clk);
        er_full    <= 1'b0;
        decoy_full <= 1'b1;
        repeat (5) @(posedge clk);
        check_value("pp_busy while blocked", pp_busy, 0);
        decoy_full <= 1'b0;
        finish_message();

        run_message(unpack_pkg::PKT_Z_BASIS_DECOY, `LEN_514, 512);
        run_message(unpack_pkg::PKT_EV_RANDOMBIT, `LEN_257, 16);
        run_message(unpack_pkg::PKT_EV_RANDOMBIT, `LEN_257, 16);

        // Full flag after 32 short EV packets and not before
        clear_ev();
        for (n = 1; n <= `RB_FULL_PACKETS; n++) begin
            check_value("ev_full before last packet", ev_full, 0);
            run_message(unpack_pkg::PKT_EV_RANDOMBIT, `LEN_257, 2);
        end
        check_value("ev_full after last packet", ev_full, 1);
        clear_ev();

        repeat (2) @(posedge clk);
        check_value("ER write count", er_cnt, er_total);
        check_value("decoy write count", decoy_cnt, decoy_total);
        check_value("random-bit write count", rb_cnt, rb_total);
        $display("Writes ER %0d, decoy %0d, random-bit %0d; errors %0d, assertion failures %0d",
                 er_cnt, decoy_cnt, rb_cnt, err_cnt, u_rx_unpacket.u_asserts.fail_cnt);
        if (err_cnt == 0 && u_rx_unpacket.u_asserts.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
